// ==== Makefile ====
# Verilator simulation of the video controller testbench

VERILATOR ?= verilator
TOP       ?= vic_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/vic_properties.sv ====
// Bound checker with a bus-driven shadow model and assertions on syncs, color, readback, irq
`timescale 1ns/1ps
`default_nettype none

module vic_properties (
  input logic                        clk,
  input logic                        rst,
  input logic                        cs_n,
  input logic                        rw,
  input logic [6:0]                  ad,
  input logic [7:0]                  db_in,
  input logic [7:0]                  db_out,
  input logic                        irq,
  input logic                        hsync,
  input logic                        vsync,
  input logic [vic_pkg::COLOR_W-1:0] color
);
  import vic_pkg::*;

  // Failed assertion count, read by the testbench
  int errors = 0;

  sprite_cfg_t            sh [NUM_SPRITES];
  logic [COLOR_W-1:0]     sh_bg;
  logic [Y_W-1:0]         sh_rc;
  int                     hx;
  int                     vy;
  int                     nx;
  int                     ny;
  logic                   wr;
  logic                   rd;
  logic                   vis_d;
  logic [NUM_SPRITES-1:0] hit_d;
  logic [COLOR_W-1:0]     col_d [NUM_SPRITES];
  logic [COLOR_W-1:0]     exp_color;
  logic [NUM_SPRITES-1:0] exp_cs;
  logic [NUM_SPRITES-1:0] coll_m;
  logic                   lm_m;
  logic                   irq_m;
  logic [7:0]             exp_db;
  logic                   hs_q;
  logic                   vs_q;
  int                     hs_run;
  int                     hs_since;
  int                     vs_run;
  int                     vs_since;

  // Sprite rule: enabled, visible, inside the box, pattern bit set
  function automatic logic sprite_hit(input sprite_cfg_t c, input int x, input int y);
    int ox;
    int oy;
    ox = x - int'(c.x);
    oy = y - int'(c.y);
    if (!c.enable || x >= H_VISIBLE || y >= V_VISIBLE) return 1'b0;
    if (ox < 0 || ox >= SPRITE_SIZE || oy < 0 || oy >= SPRITE_SIZE) return 1'b0;
    return c.pattern[SPRITE_SIZE-1-ox];
  endfunction

  // Lowest index opaque sprite wins, else background or blank
  function automatic logic [COLOR_W-1:0] mix_color();
    for (int i = 0; i < NUM_SPRITES; i++) begin
      if (hit_d[i]) return col_d[i];
    end
    return vis_d ? sh_bg : '0;
  endfunction

  function automatic logic [7:0] read_value(input logic [6:0] a);
    sprite_cfg_t c;
    c = sh[a[5:3]];
    if (!a[6]) begin
      case (a[2:0])
        3'd0:    return 8'(c.x);
        3'd1:    return 8'(c.y);
        3'd2:    return 8'(c.color);
        3'd3:    return c.pattern;
        3'd4:    return 8'(c.enable);
        default: return 8'h00;
      endcase
    end
    case (a[1:0])
      2'd0:    return 8'(sh_bg);
      2'd1:    return 8'(sh_rc);
      2'd2:    return coll_m;
      default: return 8'(irq_m);
    endcase
  endfunction

  // ==================================================
  // Shadow model
  // ==================================================

  always_comb begin
    wr = !cs_n && !rw;
    rd = !cs_n && rw;
    nx = (hx == H_TOTAL - 1) ? 0 : hx + 1;
    ny = (hx != H_TOTAL - 1) ? vy : ((vy == V_TOTAL - 1) ? 0 : vy + 1);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_SPRITES; i++) begin
        sh[i]    <= '0;
        col_d[i] <= '0;
      end
      {sh_bg, sh_rc, vis_d, hit_d, exp_color, exp_cs, coll_m} <= '0;
      {lm_m, irq_m, exp_db} <= '0;
      hx <= 0;
      vy <= 0;
    end else begin
      hx    <= nx;
      vy    <= ny;
      // Sprite stage then mixer stage
      vis_d <= (hx < H_VISIBLE) && (vy < V_VISIBLE);
      for (int i = 0; i < NUM_SPRITES; i++) begin
        hit_d[i] <= sprite_hit(sh[i], hx, vy);
        col_d[i] <= sh[i].color;
      end
      exp_color <= mix_color();
      exp_cs    <= ($countones(hit_d) > 1) ? hit_d : '0;
      lm_m      <= (nx == 0) && (ny == int'(sh_rc));
      if (lm_m) begin
        irq_m <= 1'b1;
      end else if (wr && ad[6] && ad[1:0] == 2'(REG_IRQ) && db_in[0]) begin
        irq_m <= 1'b0;
      end
      if (rd) exp_db <= read_value(ad);
      // Read clears, hits on the same edge survive
      if (rd && ad[6] && ad[1:0] == 2'(REG_COLLISION)) begin
        coll_m <= exp_cs;
      end else begin
        coll_m <= coll_m | exp_cs;
      end
      if (wr && !ad[6]) begin
        case (reg_field_e'(ad[2:0]))
          FIELD_X:       sh[ad[5:3]].x       <= db_in[X_W-1:0];
          FIELD_Y:       sh[ad[5:3]].y       <= db_in[Y_W-1:0];
          FIELD_COLOR:   sh[ad[5:3]].color   <= db_in[COLOR_W-1:0];
          FIELD_PATTERN: sh[ad[5:3]].pattern <= db_in;
          FIELD_ENABLE:  sh[ad[5:3]].enable  <= db_in[0];
          default: ;
        endcase
      end
      if (wr && ad[6] && ad[1:0] == 2'(REG_BACKGROUND)) sh_bg <= db_in[COLOR_W-1:0];
      if (wr && ad[6] && ad[1:0] == 2'(REG_RASTER_CMP)) sh_rc <= db_in[Y_W-1:0];
    end
  end

  // Sync run lengths and distance between rising edges
  always_ff @(posedge clk) begin
    if (rst) begin
      {hs_q, vs_q} <= '0;
      hs_run   <= 0;
      hs_since <= 0;
      vs_run   <= 0;
      vs_since <= 0;
    end else begin
      hs_q     <= hsync;
      vs_q     <= vsync;
      hs_run   <= hsync ? hs_run + 1 : 0;
      vs_run   <= vsync ? vs_run + 1 : 0;
      hs_since <= (hsync && !hs_q) ? 1 : ((hs_since == 0) ? 0 : hs_since + 1);
      vs_since <= (vsync && !vs_q) ? 1 : ((vs_since == 0) ? 0 : vs_since + 1);
    end
  end

  // ==================================================
  // Assertions
  // ==================================================

  a_reset_state: assert property (@(posedge clk)
    rst |=> (!hsync && !vsync && !irq && color == '0 && db_out == 8'h00))
    else begin $error("outputs not idle after reset"); errors++; end

  a_hsync_len: assert property (@(posedge clk) disable iff (rst)
    (!hsync && hs_q) |-> hs_run == H_SYNC_LEN)
    else begin $error("hsync pulse length wrong"); errors++; end

  a_hsync_period: assert property (@(posedge clk) disable iff (rst)
    (hsync && !hs_q && hs_since != 0) |-> hs_since == H_TOTAL)
    else begin $error("hsync period wrong"); errors++; end

  a_vsync_len: assert property (@(posedge clk) disable iff (rst)
    (!vsync && vs_q) |-> vs_run == V_SYNC_LEN * H_TOTAL)
    else begin $error("vsync pulse length wrong"); errors++; end

  a_vsync_period: assert property (@(posedge clk) disable iff (rst)
    (vsync && !vs_q && vs_since != 0) |-> vs_since == V_TOTAL * H_TOTAL)
    else begin $error("vsync period wrong"); errors++; end

  a_pixel_color: assert property (@(posedge clk) disable iff (rst) color == exp_color)
    else begin $error("color %0h, expected %0h", color, exp_color); errors++; end

  a_readback: assert property (@(posedge clk) disable iff (rst) db_out == exp_db)
    else begin $error("read data %0h, expected %0h", db_out, exp_db); errors++; end

  a_irq_state: assert property (@(posedge clk) disable iff (rst) irq == irq_m)
    else begin $error("irq %0b, expected %0b", irq, irq_m); errors++; end

  a_irq_line: assert property (@(posedge clk) disable iff (rst)
    (irq && !$past(irq)) |-> vy == int'(sh_rc))
    else begin $error("irq rose on line %0d", vy); errors++; end

endmodule

bind vic_top vic_properties props_i (
  .clk    (clk),
  .rst    (rst),
  .cs_n   (cs_n),
  .rw     (rw),
  .ad     (ad),
  .db_in  (db_in),
  .db_out (db_out),
  .irq    (irq),
  .hsync  (hsync),
  .vsync  (vsync),
  .color  (color)
);

`default_nettype wire

// ==== dv/vic_tb.sv ====
// Testbench with clock, reset, bus stimulus, test sequence, watchdog and result report
`timescale 1ns/1ps
`default_nettype none

module vic_tb;
  import vic_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  // Frames summed over the tests as 1 + 2 + 2 + 2 + 1 + 3
  localparam int TEST_FRAMES  = 11;

  logic               clk;
  logic               rst;
  logic               cs_n;
  logic               rw;
  logic [6:0]         ad;
  logic [7:0]         db_in;
  logic [7:0]         db_out;
  logic               irq;
  logic               hsync;
  logic               vsync;
  logic [COLOR_W-1:0] color;

  int         seed;
  int         tests_run;
  int         tests_failed;
  int         tb_errors;
  int         errors_before;
  // Last value written per address
  logic [7:0] written [128];

  vic_top vic_top_i (
    .clk    (clk),
    .rst    (rst),
    .cs_n   (cs_n),
    .rw     (rw),
    .ad     (ad),
    .db_in  (db_in),
    .db_out (db_out),
    .irq    (irq),
    .hsync  (hsync),
    .vsync  (vsync),
    .color  (color)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Run limit with 20 percent margin
  initial begin
    #(64'(TEST_FRAMES) * FRAME_CYCLES * CLK_PERIOD * 12 / 10);
    $display("Run timed out at %0t, the tests did not finish", $time);
    $display("Test FAILED");
    $finish;
  end

  // ==================================================
  // Bus tasks
  // ==================================================

  function automatic logic [6:0] sprite_addr(input int s, input int f);
    return {1'b0, 3'(s), 3'(f)};
  endfunction

  function automatic logic [6:0] glob_addr(input glob_reg_e g);
    return {1'b1, 4'b0000, 2'(g)};
  endfunction

  task automatic bus_write(input logic [6:0] a, input logic [7:0] d);
    @(posedge clk);
    cs_n  <= 1'b0;
    rw    <= 1'b0;
    ad    <= a;
    db_in <= d;
    written[a] = d;
    @(posedge clk);
    cs_n <= 1'b1;
    rw   <= 1'b1;
  endtask

  task automatic bus_read(input logic [6:0] a);
    @(posedge clk);
    cs_n <= 1'b0;
    rw   <= 1'b1;
    ad   <= a;
    @(posedge clk);
    cs_n <= 1'b1;
  endtask

  function automatic int total_errors();
    return vic_top_i.props_i.errors + tb_errors;
  endfunction

  task automatic finish_test(input string name);
    int n;
    n = total_errors() - errors_before;
    tests_run++;
    if (n > 0) begin
      tests_failed++;
      $display("error at %0t: %s saw %0d failed checks", $time, name, n);
    end else begin
      $display("%s passed at %0t", name, $time);
    end
    errors_before = total_errors();
  endtask

  task automatic place_sprite(input int s, input int x, input int y,
                              input int col, input logic [7:0] pat);
    bus_write(sprite_addr(s, 0), 8'(x));
    bus_write(sprite_addr(s, 1), 8'(y));
    bus_write(sprite_addr(s, 2), 8'(col));
    bus_write(sprite_addr(s, 3), pat);
    bus_write(sprite_addr(s, 4), 8'h01);
  endtask

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    int         s;
    int         x;
    int         y;
    int         col;
    logic [7:0] pat;
    seed = 21;
    {tests_run, tests_failed, tb_errors, errors_before} = '0;
    rst   = 1'b1;
    cs_n  = 1'b1;
    rw    = 1'b1;
    ad    = '0;
    db_in = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // Random values into every register and a read of each
    for (int i = 0; i < NUM_SPRITES; i++) begin
      for (int f = 0; f < 5; f++) bus_write(sprite_addr(i, f), 8'($random(seed)));
    end
    bus_write(glob_addr(REG_BACKGROUND), 8'($random(seed)));
    bus_write(glob_addr(REG_RASTER_CMP), 8'($random(seed)));
    for (int i = 0; i < NUM_SPRITES; i++) begin
      for (int f = 0; f < 5; f++) bus_read(sprite_addr(i, f));
    end
    bus_read(glob_addr(REG_BACKGROUND));
    bus_read(glob_addr(REG_RASTER_CMP));
    for (int i = 0; i < NUM_SPRITES; i++) bus_write(sprite_addr(i, 4), 8'h00);
    finish_test("register readback");

    // Syncs run free for two frames
    repeat (2 * FRAME_CYCLES) @(posedge clk);
    finish_test("sync timing");

    // One sprite with random pattern, place and color
    s   = $random(seed) & 7;
    x   = $random(seed) & 8'h3f;
    y   = $random(seed) & 8'h1f;
    col = $random(seed) & 15;
    pat = 8'($random(seed));
    // Sprite color differs from the background and its left column is always drawn
    if (col == int'(written[glob_addr(REG_BACKGROUND)][COLOR_W-1:0])) begin
      col = col ^ 1;
    end
    pat = pat | 8'h80;
    place_sprite(s, x, y, col, pat);
    repeat (2 * FRAME_CYCLES) @(posedge clk);
    bus_write(sprite_addr(s, 4), 8'h00);
    finish_test("single sprite");

    // Two solid sprites stacked so that sprite 1 covers sprite 4
    x = 8 + ($random(seed) & 8'h1f);
    y = 4 + ($random(seed) & 8'h0f);
    place_sprite(1, x, y, 5, 8'hff);
    place_sprite(4, x + 3, y + 2, 9, 8'hff);
    repeat (2 * FRAME_CYCLES) @(posedge clk);
    finish_test("priority");

    // Collision bits then a clean second read
    bus_write(sprite_addr(1, 4), 8'h00);
    bus_write(sprite_addr(4, 4), 8'h00);
    repeat (4) @(posedge clk);
    bus_read(glob_addr(REG_COLLISION));
    bus_read(glob_addr(REG_COLLISION));
    finish_test("collision");

    // Raster compare on a random line
    bus_write(glob_addr(REG_RASTER_CMP), 8'(($random(seed) & 32'h7fffffff) % V_TOTAL));
    bus_write(glob_addr(REG_IRQ), 8'h01);
    for (int c = 0; c < 2 * FRAME_CYCLES && !irq; c++) @(negedge clk);
    if (!irq) begin
      tb_errors++;
      $display("irq never rose for line %0d", written[glob_addr(REG_RASTER_CMP)]);
    end
    bus_read(glob_addr(REG_IRQ));
    bus_write(glob_addr(REG_IRQ), 8'h01);
    repeat (3) @(posedge clk);
    bus_read(glob_addr(REG_IRQ));
    repeat (4) @(posedge clk);
    finish_test("raster interrupt");

    $display("%0d tests run, %0d failed, %0d failed checks",
             tests_run, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/vic_pkg.sv
source/vic_regs.sv
source/vic_raster.sv
source/vic_sprite.sv
source/vic_priority.sv
source/vic_top.sv
dv/vic_properties.sv
dv/vic_tb.sv

// ==== source/vic_pkg.sv ====
// Screen timing, sprite size constants, register address enums and shared structs
`default_nettype none

package vic_pkg;

  // ==================================================
  // Screen timing, kept small for simulation
  // ==================================================

  // Pixels per line
  localparam int H_VISIBLE    = 64;
  localparam int H_TOTAL      = 80;
  localparam int H_SYNC_START = 68;
  localparam int H_SYNC_LEN   = 6;

  // Lines per frame
  localparam int V_VISIBLE    = 32;
  localparam int V_TOTAL      = 40;
  localparam int V_SYNC_START = 34;
  localparam int V_SYNC_LEN   = 2;

  // Beam position to color output, in cycles
  localparam int PIPE_DELAY   = 2;

  // ==================================================
  // Sprites and field widths
  // ==================================================

  localparam int NUM_SPRITES  = 8;
  localparam int SPRITE_SIZE  = 8;
  // Column offset inside one sprite row
  localparam int SPRITE_OFS_W = $clog2(SPRITE_SIZE);

  // Beam coordinates and color index
  localparam int X_W          = 7;
  localparam int Y_W          = 6;
  localparam int COLOR_W      = 4;

  // Per-sprite fields, ad[2:0] with ad[6] low
  typedef enum logic [2:0] {
    FIELD_X       = 3'd0,
    FIELD_Y       = 3'd1,
    FIELD_COLOR   = 3'd2,
    FIELD_PATTERN = 3'd3,
    FIELD_ENABLE  = 3'd4
  } reg_field_e;

  // Global registers, ad[1:0] with ad[6] high
  typedef enum logic [1:0] {
    REG_BACKGROUND = 2'd0,
    REG_RASTER_CMP = 2'd1,
    REG_COLLISION  = 2'd2,
    REG_IRQ        = 2'd3
  } glob_reg_e;

  // One sprite's configuration, 26 bits
  typedef struct packed {
    logic                   enable;
    logic [X_W-1:0]         x;
    logic [Y_W-1:0]         y;
    logic [COLOR_W-1:0]     color;
    logic [SPRITE_SIZE-1:0] pattern;
  } sprite_cfg_t;

  // Beam position with its qualifiers
  typedef struct packed {
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
    logic           visible;
    logic           hsync;
    logic           vsync;
  } beam_t;

  // Sprite unit output
  typedef struct packed {
    logic               opaque;
    logic [COLOR_W-1:0] color;
  } sprite_pix_t;

endpackage

`default_nettype wire

// ==== source/vic_priority.sv ====
// Sprite priority mixer with background fill, blanking, collisions and sync delay
`timescale 1ns/1ps
`default_nettype none

module vic_priority (
  input  logic                                            clk,
  input  logic                                            rst,
  input  vic_pkg::beam_t                                  beam,
  input  vic_pkg::sprite_pix_t [vic_pkg::NUM_SPRITES-1:0] pix,
  input  logic [vic_pkg::COLOR_W-1:0]                     background,
  output logic [vic_pkg::COLOR_W-1:0]                     color,
  output logic                                            hsync,
  output logic                                            vsync,
  output logic [vic_pkg::NUM_SPRITES-1:0]                 collision_set
);
  import vic_pkg::*;

  // Beam delayed to line up with the sprite pixels
  beam_t                  beam_d [PIPE_DELAY-1];
  beam_t                  beam_al;
  logic [NUM_SPRITES-1:0] opq;
  logic                   collide;
  logic [COLOR_W-1:0]     color_next;

  // ==================================================
  // Beam alignment
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PIPE_DELAY - 1; i++) begin
        beam_d[i] <= '0;
      end
    end else begin
      beam_d[0] <= beam;
      for (int i = 1; i < PIPE_DELAY - 1; i++) begin
        beam_d[i] <= beam_d[i-1];
      end
    end
  end

  assign beam_al = beam_d[PIPE_DELAY-2];

  // ==================================================
  // Mixer
  // ==================================================

  always_comb begin
    // Blanking gives 0, visible area gives background
    color_next = beam_al.visible ? background : '0;
    // Walk downwards so the lowest index wins
    for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
      opq[i] = pix[i].opaque;
      if (pix[i].opaque) begin
        color_next = pix[i].color;
      end
    end
  end

  // More than one bit set means a sprite-to-sprite hit
  assign collide = |(opq & (opq - 1'b1));

  // Output stage, one cycle after the sprite pixels
  always_ff @(posedge clk) begin
    if (rst) begin
      color         <= '0;
      hsync         <= 1'b0;
      vsync         <= 1'b0;
      collision_set <= '0;
    end else begin
      color         <= color_next;
      hsync         <= beam_al.hsync;
      vsync         <= beam_al.vsync;
      collision_set <= collide ? opq : '0;
    end
  end

endmodule

`default_nettype wire

// ==== source/vic_raster.sv ====
// Beam counters, sync windows and the raster compare pulse
`timescale 1ns/1ps
`default_nettype none

module vic_raster (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [vic_pkg::Y_W-1:0]   raster_cmp,
  output vic_pkg::beam_t            beam,
  output logic                      line_match
);
  import vic_pkg::*;

  beam_t beam_next;

  // ==================================================
  // Next beam position
  // ==================================================

  always_comb begin
    beam_next = beam;
    // Pixel counter wraps at H_TOTAL, line counter at V_TOTAL
    if (beam.x == X_W'(H_TOTAL - 1)) begin
      beam_next.x = '0;
      if (beam.y == Y_W'(V_TOTAL - 1)) begin
        beam_next.y = '0;
      end else begin
        beam_next.y = beam.y + 1'b1;
      end
    end else begin
      beam_next.x = beam.x + 1'b1;
    end
    // Qualifiers follow the new position so they stay in step
    beam_next.visible = (beam_next.x < X_W'(H_VISIBLE)) &&
                        (beam_next.y < Y_W'(V_VISIBLE));
    beam_next.hsync   = (beam_next.x >= X_W'(H_SYNC_START)) &&
                        (beam_next.x <  X_W'(H_SYNC_START + H_SYNC_LEN));
    // Vertical sync covers whole lines
    beam_next.vsync   = (beam_next.y >= Y_W'(V_SYNC_START)) &&
                        (beam_next.y <  Y_W'(V_SYNC_START + V_SYNC_LEN));
  end

  // ==================================================
  // Registered beam and compare event
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      // Top left corner, visible, no sync
      beam       <= '{x: '0, y: '0, visible: 1'b1, hsync: 1'b0, vsync: 1'b0};
      line_match <= 1'b0;
    end else begin
      beam       <= beam_next;
      // High while the beam sits on pixel 0 of the compared line
      line_match <= (beam_next.x == '0) && (beam_next.y == raster_cmp);
    end
  end

endmodule

`default_nettype wire

// ==== source/vic_regs.sv ====
// Host bus decode, sprite and global registers, read mux, collision and irq status
`timescale 1ns/1ps
`default_nettype none

module vic_regs (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic                                             cs_n,
  input  logic                                             rw,
  input  logic [6:0]                                       ad,
  input  logic [7:0]                                       db_in,
  output logic [7:0]                                       db_out,
  output logic                                             irq,
  output vic_pkg::sprite_cfg_t [vic_pkg::NUM_SPRITES-1:0]  sprite_cfg,
  output logic [vic_pkg::COLOR_W-1:0]                      background,
  output logic [vic_pkg::Y_W-1:0]                          raster_cmp,
  input  logic                                             line_match,
  input  logic [vic_pkg::NUM_SPRITES-1:0]                  collision_set
);
  import vic_pkg::*;

  logic                   wr_en;
  logic                   rd_en;
  logic                   wr_sprite;
  logic                   wr_glob;
  logic                   rd_glob;
  logic [2:0]             sel;
  reg_field_e             field;
  glob_reg_e              glob;
  logic [NUM_SPRITES-1:0] collision;
  logic [7:0]             rd_data;

  // ==================================================
  // Bus decode
  // ==================================================

  // Strobes are sampled on the rising edge
  assign wr_en     = !cs_n && !rw;
  assign rd_en     = !cs_n && rw;
  // ad[6] picks sprite space or global space
  assign wr_sprite = wr_en && !ad[6];
  assign wr_glob   = wr_en && ad[6];
  assign rd_glob   = rd_en && ad[6];
  assign sel       = ad[5:3];
  assign field     = reg_field_e'(ad[2:0]);
  assign glob      = glob_reg_e'(ad[1:0]);

  // Sprite fields, only enable is cleared by reset
  always_ff @(posedge clk) begin
    if (wr_sprite) begin
      case (field)
        FIELD_X:       sprite_cfg[sel].x       <= db_in[X_W-1:0];
        FIELD_Y:       sprite_cfg[sel].y       <= db_in[Y_W-1:0];
        FIELD_COLOR:   sprite_cfg[sel].color   <= db_in[COLOR_W-1:0];
        FIELD_PATTERN: sprite_cfg[sel].pattern <= db_in;
        FIELD_ENABLE:  sprite_cfg[sel].enable  <= db_in[0];
        default: ;
      endcase
    end
    if (rst) begin
      for (int i = 0; i < NUM_SPRITES; i++) begin
        sprite_cfg[i].enable <= 1'b0;
      end
    end
  end

  // ==================================================
  // Global registers and status
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      background <= '0;
      raster_cmp <= '0;
    end else if (wr_glob) begin
      if (glob == REG_BACKGROUND) begin
        background <= db_in[COLOR_W-1:0];
      end
      if (glob == REG_RASTER_CMP) begin
        raster_cmp <= db_in[Y_W-1:0];
      end
    end
  end

  // Collision bits are sticky; a read clears them,
  // but hits arriving on the read edge are kept
  always_ff @(posedge clk) begin
    if (rst) begin
      collision <= '0;
    end else if (rd_glob && glob == REG_COLLISION) begin
      collision <= collision_set;
    end else begin
      collision <= collision | collision_set;
    end
  end

  // Raster irq status, set by line_match, cleared by writing 1 to bit 0
  // A new match on the clear edge wins
  always_ff @(posedge clk) begin
    if (rst) begin
      irq <= 1'b0;
    end else if (line_match) begin
      irq <= 1'b1;
    end else if (wr_glob && glob == REG_IRQ && db_in[0]) begin
      irq <= 1'b0;
    end
  end

  // ==================================================
  // Read path
  // ==================================================

  always_comb begin
    rd_data = '0;
    if (!ad[6]) begin
      case (field)
        FIELD_X:       rd_data = 8'(sprite_cfg[sel].x);
        FIELD_Y:       rd_data = 8'(sprite_cfg[sel].y);
        FIELD_COLOR:   rd_data = 8'(sprite_cfg[sel].color);
        FIELD_PATTERN: rd_data = sprite_cfg[sel].pattern;
        FIELD_ENABLE:  rd_data = 8'(sprite_cfg[sel].enable);
        default:       rd_data = '0;
      endcase
    end else begin
      case (glob)
        REG_BACKGROUND: rd_data = 8'(background);
        REG_RASTER_CMP: rd_data = 8'(raster_cmp);
        REG_COLLISION:  rd_data = collision;
        REG_IRQ:        rd_data = 8'(irq);
        default:        rd_data = '0;
      endcase
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk) begin
    if (rst) begin
      db_out <= '0;
    end else if (rd_en) begin
      db_out <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/vic_sprite.sv ====
// Single sprite unit, beam position plus configuration to one sprite pixel
`timescale 1ns/1ps
`default_nettype none

module vic_sprite (
  input  logic                  clk,
  input  logic                  rst,
  input  vic_pkg::sprite_cfg_t  cfg,
  input  vic_pkg::beam_t        beam,
  output vic_pkg::sprite_pix_t  pix
);
  import vic_pkg::*;

  logic [X_W-1:0]          dx;
  logic [Y_W-1:0]          dy;
  logic [SPRITE_OFS_W-1:0] col;
  logic                    in_box;
  logic                    bit_on;

  // Offsets from the sprite's top left corner
  assign dx = beam.x - cfg.x;
  assign dy = beam.y - cfg.y;

  // The >= checks stop wrap-around, so boxes past the edge are clipped
  assign in_box = (beam.x >= cfg.x) && (dx < X_W'(SPRITE_SIZE)) &&
                  (beam.y >= cfg.y) && (dy < Y_W'(SPRITE_SIZE));

  // MSB of the pattern is the leftmost pixel
  assign col    = SPRITE_OFS_W'(SPRITE_SIZE - 1) - dx[SPRITE_OFS_W-1:0];
  // Same row pattern on every line of the box
  assign bit_on = cfg.pattern[col];

  // Pixel lags the beam by one cycle
  always_ff @(posedge clk) begin
    pix.color <= cfg.color;
    if (rst) begin
      pix.opaque <= 1'b0;
    end else begin
      pix.opaque <= cfg.enable && beam.visible && in_box && bit_on;
    end
  end

endmodule

`default_nettype wire

// ==== source/vic_top.sv ====
// Video controller top level with registers, raster, sprite array and mixer
`timescale 1ns/1ps
`default_nettype none

module vic_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cs_n,
  input  logic                          rw,
  input  logic [6:0]                    ad,
  input  logic [7:0]                    db_in,
  output logic [7:0]                    db_out,
  output logic                          irq,
  output logic                          hsync,
  output logic                          vsync,
  output logic [vic_pkg::COLOR_W-1:0]   color
);
  import vic_pkg::*;

  sprite_cfg_t [NUM_SPRITES-1:0] sprite_cfg;
  sprite_pix_t [NUM_SPRITES-1:0] sprite_pix;
  beam_t                         beam;
  logic [COLOR_W-1:0]            background;
  logic [Y_W-1:0]                raster_cmp;
  logic                          line_match;
  logic [NUM_SPRITES-1:0]        collision_set;

  // ==================================================
  // Host registers
  // ==================================================

  vic_regs regs_i (
    .clk           (clk),
    .rst           (rst),
    .cs_n          (cs_n),
    .rw            (rw),
    .ad            (ad),
    .db_in         (db_in),
    .db_out        (db_out),
    .irq           (irq),
    .sprite_cfg    (sprite_cfg),
    .background    (background),
    .raster_cmp    (raster_cmp),
    .line_match    (line_match),
    .collision_set (collision_set)
  );

  // Beam generator
  vic_raster raster_i (
    .clk        (clk),
    .rst        (rst),
    .raster_cmp (raster_cmp),
    .beam       (beam),
    .line_match (line_match)
  );

  // ==================================================
  // Sprite array and mixer
  // ==================================================

  for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_sprite
    vic_sprite sprite_i (
      .clk  (clk),
      .rst  (rst),
      .cfg  (sprite_cfg[i]),
      .beam (beam),
      .pix  (sprite_pix[i])
    );
  end

  vic_priority priority_i (
    .clk           (clk),
    .rst           (rst),
    .beam          (beam),
    .pix           (sprite_pix),
    .background    (background),
    .color         (color),
    .hsync         (hsync),
    .vsync         (vsync),
    .collision_set (collision_set)
  );

endmodule

`default_nettype wire
